//--- verilog/axi_pkg.sv
package axi_pkg;

	//////////////////////////////////////////////////////////////////////
	// Response codes
	//////////////////////////////////////////////////////////////////////

	typedef logic [1:0] resp_t;

	// Only OKAY is ever returned by this slave
	localparam resp_t RESP_OKAY = 2'b00;

	//////////////////////////////////////////////////////////////////////
	// Channel controller state
	//////////////////////////////////////////////////////////////////////

	// IDLE    waiting for a request
	// ACCEPT  ready high for one cycle
	// MEM     RAM request in progress
	// RESP    response held until the master takes it
	typedef enum logic [1:0] {
		IDLE,
		ACCEPT,
		MEM,
		RESP
	} chan_state_t;

endpackage

//--- verilog/mem_pkg.sv
package mem_pkg;

	//////////////////////////////////////////////////////////////////////
	// RAM side constants
	//////////////////////////////////////////////////////////////////////

	// Cycles from request accept to data done
	localparam int RAM_LATENCY = 1;

	// Width of one write-enable lane
	localparam int BYTE_WIDTH = 8;

	// Done strobe pipeline, one bit per latency stage
	typedef logic [RAM_LATENCY-1:0] lat_t;

endpackage

//--- verilog/dp_sram.sv
module dp_sram #(
	parameter int DATA_WIDTH = 32,
	parameter int MEM_DEPTH  = 256,
	localparam int STRB_WIDTH = DATA_WIDTH / 8,
	localparam int IDX_WIDTH  = $clog2(MEM_DEPTH)
) (
	input  logic                  ACLK,
	input  logic                  ARESETn,

	// Read port
	input  logic                  req_a,
	input  logic [IDX_WIDTH-1:0]  addr_a,
	output logic [DATA_WIDTH-1:0] dout_a,
	output logic                  addr_ok_a,
	output logic                  data_ok_a,

	// Byte-masked write port
	input  logic                  req_b,
	input  logic                  we_b,
	input  logic [IDX_WIDTH-1:0]  addr_b,
	input  logic [DATA_WIDTH-1:0] din_b,
	input  logic [STRB_WIDTH-1:0] wem_b,
	output logic                  addr_ok_b,
	output logic                  data_ok_b
);

	localparam int BW = mem_pkg::BYTE_WIDTH;

	typedef logic [DATA_WIDTH-1:0] word_t;

	word_t         mem [MEM_DEPTH];
	mem_pkg::lat_t ok_a_pipe;
	mem_pkg::lat_t ok_b_pipe;

	// Both ports take a request in the cycle it arrives
	assign addr_ok_a = req_a;
	assign addr_ok_b = req_b;

	// Read and write on the same edge, so a colliding read sees the old word
	always_ff @(posedge ACLK) begin
		if (req_a)
			dout_a <= mem[addr_a];
		if (req_b && we_b) begin
			for (int i = 0; i < STRB_WIDTH; i++) begin
				if (wem_b[i])
					mem[addr_b][i*BW +: BW] <= din_b[i*BW +: BW];
			end
		end
	end

	// Done strobes trail the accept by RAM_LATENCY cycles
	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			ok_a_pipe <= '0;
			ok_b_pipe <= '0;
		end else begin
			ok_a_pipe <= (ok_a_pipe << 1) | mem_pkg::lat_t'(req_a);
			ok_b_pipe <= (ok_b_pipe << 1) | mem_pkg::lat_t'(req_b);
		end
	end

	assign data_ok_a = ok_a_pipe[mem_pkg::RAM_LATENCY-1];
	assign data_ok_b = ok_b_pipe[mem_pkg::RAM_LATENCY-1];

endmodule

//--- verilog/axi_write_ctrl.sv
module axi_write_ctrl #(
	parameter int DATA_WIDTH = 32,
	parameter int ADDR_WIDTH = 32,
	parameter int ID_WIDTH   = 6,
	parameter int MEM_DEPTH  = 256,
	localparam int STRB_WIDTH = DATA_WIDTH / 8,
	localparam int IDX_WIDTH  = $clog2(MEM_DEPTH)
) (
	input  logic                  ACLK,
	input  logic                  ARESETn,

	input  logic [ADDR_WIDTH-1:0] AWADDR,
	input  logic [ID_WIDTH-1:0]   AWID,
	input  logic                  AWVALID,
	output logic                  AWREADY,

	input  logic [DATA_WIDTH-1:0] WDATA,
	input  logic [STRB_WIDTH-1:0] WSTRB,
	input  logic                  WVALID,
	output logic                  WREADY,

	output logic [ID_WIDTH-1:0]   BID,
	output axi_pkg::resp_t        BRESP,
	output logic                  BVALID,
	input  logic                  BREADY,

	output logic                  req,
	output logic                  we,
	output logic [IDX_WIDTH-1:0]  addr,
	output logic [DATA_WIDTH-1:0] din,
	output logic [STRB_WIDTH-1:0] wem,
	input  logic                  addr_ok,
	input  logic                  data_ok
);

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [ID_WIDTH-1:0]   id_t;
	typedef logic [IDX_WIDTH-1:0]  idx_t;

	axi_pkg::chan_state_t state;
	id_t   id_q;
	addr_t aw_word;
	logic  aw_fire;
	logic  b_fire;

	// AW and W complete on the same edge
	assign aw_fire = AWVALID && AWREADY && WVALID && WREADY;
	assign b_fire  = BVALID && BREADY;

	// Byte address to word address, upper bits wrap in the RAM
	assign aw_word = AWADDR >> 2;

	//////////////////////////////////////////////////////////////////////
	// Write channel FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			state   <= axi_pkg::IDLE;
			AWREADY <= 1'b0;
			WREADY  <= 1'b0;
			BVALID  <= 1'b0;
			req     <= 1'b0;
		end else begin
			case (state)
				axi_pkg::IDLE: begin
					if (AWVALID && WVALID) begin
						state   <= axi_pkg::ACCEPT;
						AWREADY <= 1'b1;
						WREADY  <= 1'b1;
					end
				end
				axi_pkg::ACCEPT: begin
					AWREADY <= 1'b0;
					WREADY  <= 1'b0;
					state   <= aw_fire ? axi_pkg::MEM : axi_pkg::IDLE;
					req     <= aw_fire;
				end
				axi_pkg::MEM: begin
					// RAM takes the request in the cycle it is raised
					if (addr_ok)
						req <= 1'b0;
					if (data_ok) begin
						BVALID <= 1'b1;
						state  <= axi_pkg::RESP;
					end
				end
				axi_pkg::RESP: begin
					if (b_fire) begin
						BVALID <= 1'b0;
						state  <= axi_pkg::IDLE;
					end
				end
				default: state <= axi_pkg::IDLE;
			endcase
		end
	end

	// Captured on the AW/W transfer
	always_ff @(posedge ACLK) begin
		if (aw_fire) begin
			id_q <= AWID;
			addr <= idx_t'(aw_word);
			din  <= WDATA;
			wem  <= WSTRB;
		end
	end

	assign we    = req;
	assign BID   = BVALID ? id_q : '0;
	assign BRESP = axi_pkg::RESP_OKAY;

endmodule

//--- verilog/axi_read_ctrl.sv
module axi_read_ctrl #(
	parameter int DATA_WIDTH = 32,
	parameter int ADDR_WIDTH = 32,
	parameter int ID_WIDTH   = 6,
	parameter int MEM_DEPTH  = 256,
	localparam int IDX_WIDTH = $clog2(MEM_DEPTH)
) (
	input  logic                  ACLK,
	input  logic                  ARESETn,

	input  logic [ADDR_WIDTH-1:0] ARADDR,
	input  logic [ID_WIDTH-1:0]   ARID,
	input  logic                  ARVALID,
	output logic                  ARREADY,

	output logic [DATA_WIDTH-1:0] RDATA,
	output axi_pkg::resp_t        RRESP,
	output logic                  RLAST,
	output logic [ID_WIDTH-1:0]   RID,
	output logic                  RVALID,
	input  logic                  RREADY,

	output logic                  req,
	output logic [IDX_WIDTH-1:0]  addr,
	input  logic                  addr_ok,
	input  logic                  data_ok,
	input  logic [DATA_WIDTH-1:0] dout
);

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [ID_WIDTH-1:0]   id_t;
	typedef logic [IDX_WIDTH-1:0]  idx_t;

	axi_pkg::chan_state_t state;
	id_t   id_q;
	addr_t ar_word;
	logic  ar_fire;
	logic  r_fire;

	assign ar_fire = ARVALID && ARREADY;
	assign r_fire  = RVALID && RREADY;
	assign ar_word = ARADDR >> 2;

	//////////////////////////////////////////////////////////////////////
	// Read channel FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			state   <= axi_pkg::IDLE;
			ARREADY <= 1'b0;
			RVALID  <= 1'b0;
			RLAST   <= 1'b0;
			req     <= 1'b0;
		end else begin
			case (state)
				axi_pkg::IDLE: begin
					if (ARVALID) begin
						state   <= axi_pkg::ACCEPT;
						ARREADY <= 1'b1;
					end
				end
				axi_pkg::ACCEPT: begin
					ARREADY <= 1'b0;
					state   <= ar_fire ? axi_pkg::MEM : axi_pkg::IDLE;
					req     <= ar_fire;
				end
				axi_pkg::MEM: begin
					if (addr_ok)
						req <= 1'b0;
					// Single beat, so the only beat is also the last
					if (data_ok) begin
						RVALID <= 1'b1;
						RLAST  <= 1'b1;
						state  <= axi_pkg::RESP;
					end
				end
				axi_pkg::RESP: begin
					if (r_fire) begin
						RVALID <= 1'b0;
						RLAST  <= 1'b0;
						state  <= axi_pkg::IDLE;
					end
				end
				default: state <= axi_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge ACLK) begin
		if (ar_fire) begin
			id_q <= ARID;
			addr <= idx_t'(ar_word);
		end
		// Word is valid only in the done cycle
		if (data_ok)
			RDATA <= dout;
	end

	assign RID   = RVALID ? id_q : '0;
	assign RRESP = axi_pkg::RESP_OKAY;

endmodule

//--- verilog/axi_sram_top.sv
module axi_sram_top #(
	parameter int DATA_WIDTH = 32,
	parameter int ADDR_WIDTH = 32,
	parameter int ID_WIDTH   = 6,
	parameter int MEM_DEPTH  = 256,
	localparam int STRB_WIDTH = DATA_WIDTH / 8
) (
	input  logic                  ACLK,
	input  logic                  ARESETn,

	input  logic [ADDR_WIDTH-1:0] AWADDR,
	input  logic [ID_WIDTH-1:0]   AWID,
	input  logic                  AWVALID,
	output logic                  AWREADY,

	input  logic [DATA_WIDTH-1:0] WDATA,
	input  logic [STRB_WIDTH-1:0] WSTRB,
	input  logic                  WVALID,
	output logic                  WREADY,

	output logic [ID_WIDTH-1:0]   BID,
	output axi_pkg::resp_t        BRESP,
	output logic                  BVALID,
	input  logic                  BREADY,

	input  logic [ADDR_WIDTH-1:0] ARADDR,
	input  logic [ID_WIDTH-1:0]   ARID,
	input  logic                  ARVALID,
	output logic                  ARREADY,

	output logic [DATA_WIDTH-1:0] RDATA,
	output axi_pkg::resp_t        RRESP,
	output logic                  RLAST,
	output logic [ID_WIDTH-1:0]   RID,
	output logic                  RVALID,
	input  logic                  RREADY
);

	localparam int IDX_WIDTH = $clog2(MEM_DEPTH);

	typedef logic [DATA_WIDTH-1:0] word_t;
	typedef logic [STRB_WIDTH-1:0] strb_t;
	typedef logic [IDX_WIDTH-1:0]  idx_t;

	// RAM port A, read side
	logic  req_a, addr_ok_a, data_ok_a;
	idx_t  addr_a;
	word_t dout_a;

	// RAM port B, write side
	logic  req_b, we_b, addr_ok_b, data_ok_b;
	idx_t  addr_b;
	word_t din_b;
	strb_t wem_b;

	axi_write_ctrl #(
		.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH),
		.ID_WIDTH(ID_WIDTH), .MEM_DEPTH(MEM_DEPTH)
	) u_write_ctrl (
		.ACLK(ACLK), .ARESETn(ARESETn),
		.AWADDR(AWADDR), .AWID(AWID), .AWVALID(AWVALID), .AWREADY(AWREADY),
		.WDATA(WDATA), .WSTRB(WSTRB), .WVALID(WVALID), .WREADY(WREADY),
		.BID(BID), .BRESP(BRESP), .BVALID(BVALID), .BREADY(BREADY),
		.req(req_b), .we(we_b), .addr(addr_b), .din(din_b), .wem(wem_b),
		.addr_ok(addr_ok_b), .data_ok(data_ok_b)
	);

	axi_read_ctrl #(
		.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH),
		.ID_WIDTH(ID_WIDTH), .MEM_DEPTH(MEM_DEPTH)
	) u_read_ctrl (
		.ACLK(ACLK), .ARESETn(ARESETn),
		.ARADDR(ARADDR), .ARID(ARID), .ARVALID(ARVALID), .ARREADY(ARREADY),
		.RDATA(RDATA), .RRESP(RRESP), .RLAST(RLAST), .RID(RID),
		.RVALID(RVALID), .RREADY(RREADY),
		.req(req_a), .addr(addr_a), .addr_ok(addr_ok_a), .data_ok(data_ok_a),
		.dout(dout_a)
	);

	dp_sram #(
		.DATA_WIDTH(DATA_WIDTH), .MEM_DEPTH(MEM_DEPTH)
	) u_sram (
		.ACLK(ACLK), .ARESETn(ARESETn),
		.req_a(req_a), .addr_a(addr_a), .dout_a(dout_a),
		.addr_ok_a(addr_ok_a), .data_ok_a(data_ok_a),
		.req_b(req_b), .we_b(we_b), .addr_b(addr_b), .din_b(din_b), .wem_b(wem_b),
		.addr_ok_b(addr_ok_b), .data_ok_b(data_ok_b)
	);

endmodule

//--- tests/axi_sram_checker.sv
module axi_sram_checker #(
	parameter int DATA_WIDTH = 32,
	parameter int ADDR_WIDTH = 32,
	parameter int ID_WIDTH   = 6,
	parameter int MEM_DEPTH  = 256
) (
	input  logic                    ACLK,
	input  logic                    ARESETn,
	input  logic [ADDR_WIDTH-1:0]   AWADDR,
	input  logic [ID_WIDTH-1:0]     AWID,
	input  logic                    AWVALID, AWREADY,
	input  logic [DATA_WIDTH-1:0]   WDATA,
	input  logic [DATA_WIDTH/8-1:0] WSTRB,
	input  logic                    WVALID, WREADY,
	input  logic [ID_WIDTH-1:0]     BID,
	input  axi_pkg::resp_t          BRESP,
	input  logic                    BVALID, BREADY,
	input  logic [ADDR_WIDTH-1:0]   ARADDR,
	input  logic [ID_WIDTH-1:0]     ARID,
	input  logic                    ARVALID, ARREADY,
	input  logic [DATA_WIDTH-1:0]   RDATA,
	input  axi_pkg::resp_t          RRESP,
	input  logic [ID_WIDTH-1:0]     RID,
	input  logic                    RLAST, RVALID, RREADY,
	// Expected read word from the stimulus table
	input  logic [DATA_WIDTH-1:0]   tbl_rdata,
	input  logic                    tbl_chk,
	output int                      errors,
	output int                      writes_done,
	output int                      reads_done
);
	timeunit 1ns;
	timeprecision 1ps;

	typedef logic [DATA_WIDTH-1:0] word_t;
	typedef logic [ID_WIDTH-1:0]   id_t;

	// Transfer edge to first VALID, fixed by the controller FSMs
	localparam int RESP_CYCLES = mem_pkg::RAM_LATENCY + 2;

	word_t model [MEM_DEPTH];
	id_t   exp_bid, exp_rid, last_bid, last_rid;
	word_t exp_rdata, last_rdata;
	logic  w_pend, r_pend, b_hold, r_hold, in_reset;
	int    w_age, r_age, widx;

	// Low two bits dropped, word index wraps at the depth
	function automatic int word_index(logic [ADDR_WIDTH-1:0] a);
		return int'((a >> 2) % MEM_DEPTH);
	endfunction

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR @%0t: %s", $time, msg);
	endtask

	always @(posedge ACLK) begin
		if (!ARESETn) begin
			in_reset = 1'b1;
			w_pend = 1'b0;
			r_pend = 1'b0;
			b_hold = 1'b0;
			r_hold = 1'b0;
			errors = 0;
			writes_done = 0;
			reads_done = 0;
			foreach (model[i])
				model[i] = 'x;
		end else begin
			if (in_reset && (AWREADY || WREADY || ARREADY || BVALID || RVALID || RLAST))
				report_error("READY or VALID output high after reset");
			in_reset = 1'b0;
			if ((!BVALID && BID != '0) || (!RVALID && RID != '0))
				report_error($sformatf("idle BID %0h or RID %0h not zero", BID, RID));

			//////////////////////////////////////////////////////////////////////
			// Held responses and latency
			//////////////////////////////////////////////////////////////////////
			if (b_hold && (!BVALID || BID !== last_bid))
				report_error("B response changed before BREADY");
			if (r_hold && (!RVALID || !RLAST || RDATA !== last_rdata || RID !== last_rid))
				report_error("R response changed before RREADY");
			if (w_pend)
				w_age++;
			if (r_pend)
				r_age++;
			if (w_pend && BVALID && !b_hold && w_age != RESP_CYCLES)
				report_error($sformatf("BVALID after %0d cycles, expected %0d", w_age, RESP_CYCLES));
			if (r_pend && RVALID && !r_hold && r_age != RESP_CYCLES)
				report_error($sformatf("RVALID after %0d cycles, expected %0d", r_age, RESP_CYCLES));

			// Response transfers
			if (BVALID && BREADY) begin
				if (!w_pend)
					report_error("write response without a write transfer");
				else if (BID !== exp_bid || BRESP !== axi_pkg::RESP_OKAY)
					report_error($sformatf("BID %0h BRESP %0d, expected %0h OKAY", BID, BRESP, exp_bid));
				w_pend = 1'b0;
				writes_done++;
			end
			if (RVALID && RREADY) begin
				if (!r_pend)
					report_error("read response without a read transfer");
				else if (RDATA !== exp_rdata || RID !== exp_rid)
					report_error($sformatf("RDATA %h RID %0h, expected %h %0h",
						RDATA, RID, exp_rdata, exp_rid));
				if (RRESP !== axi_pkg::RESP_OKAY || !RLAST)
					report_error("RRESP not OKAY or RLAST low");
				if (tbl_chk && RDATA !== tbl_rdata)
					report_error($sformatf("RDATA %h, table expects %h", RDATA, tbl_rdata));
				r_pend = 1'b0;
				reads_done++;
			end

			// Read predicted first so a same-edge write is not seen
			if (ARVALID && ARREADY) begin
				r_pend = 1'b1;
				r_age = 0;
				exp_rid = ARID;
				exp_rdata = model[word_index(ARADDR)];
			end
			if (AWVALID && AWREADY && WVALID && WREADY) begin
				w_pend = 1'b1;
				w_age = 0;
				exp_bid = AWID;
				widx = word_index(AWADDR);
				for (int i = 0; i < DATA_WIDTH / 8; i++)
					if (WSTRB[i])
						model[widx][i*8 +: 8] = WDATA[i*8 +: 8];
			end

			b_hold = BVALID && !BREADY;
			r_hold = RVALID && !RREADY;
			last_bid = BID;
			last_rid = RID;
			last_rdata = RDATA;
		end
	end

endmodule

//--- tests/tb_axi_sram.sv
module tb_axi_sram;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int DATA_WIDTH = 32;
	localparam int ADDR_WIDTH = 32;
	localparam int ID_WIDTH   = 6;
	localparam int MEM_DEPTH  = 256;
	localparam int NUM_ROWS   = 14;
	localparam int MAX_CYCLES = 40 * NUM_ROWS + 20;

	localparam logic [1:0] OP_WR   = 2'd0;
	localparam logic [1:0] OP_RD   = 2'd1;
	localparam logic [1:0] OP_BOTH = 2'd2;
	// Ready delay drawn from 0 to 4
	localparam logic [3:0] RND     = 4'hf;

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [ID_WIDTH-1:0]   id_t;

	typedef struct packed {
		logic [1:0]  op;
		logic [11:0] waddr;
		logic [31:0] wdata;
		logic        rnd_data;
		logic [3:0]  strb;
		id_t         wid;
		logic [11:0] raddr;
		id_t         rid;
		logic [31:0] rdata;
		logic        chk;
		logic [3:0]  dly;
	} row_t;

	logic ACLK, ARESETn;
	addr_t AWADDR, ARADDR;
	id_t AWID, BID, ARID, RID;
	logic [DATA_WIDTH-1:0] WDATA, RDATA, tbl_rdata;
	logic [DATA_WIDTH/8-1:0] WSTRB;
	axi_pkg::resp_t BRESP, RRESP;
	logic AWVALID, AWREADY, WVALID, WREADY, BVALID, BREADY;
	logic ARVALID, ARREADY, RLAST, RVALID, RREADY, tbl_chk;

	row_t rows [NUM_ROWS];
	int errors, writes_done, reads_done, exp_writes, exp_reads;
	int cycles = 0;

	axi_sram_top #(
		.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH),
		.ID_WIDTH(ID_WIDTH), .MEM_DEPTH(MEM_DEPTH)
	) uut (.*);

	axi_sram_checker #(
		.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH),
		.ID_WIDTH(ID_WIDTH), .MEM_DEPTH(MEM_DEPTH)
	) chk (.*);

	always #5 ACLK = ~ACLK;

	//////////////////////////////////////////////////////////////////////
	// Stimulus table
	//////////////////////////////////////////////////////////////////////

	// op, waddr, wdata, rnd_data, strb, wid, raddr, rid, exp rdata, chk, dly
	task automatic load_table();
		rows[0]  = '{OP_WR, 12'h000, 32'hdeadbeef, '0, 4'hf, 6'h01, '0, '0, '0, '0, 4'd0};
		rows[1]  = '{OP_RD, '0, '0, '0, '0, '0, 12'h000, 6'h02, 32'hdeadbeef, '1, 4'd0};
		rows[2]  = '{OP_WR, 12'h004, 32'h11223344, '0, 4'hf, 6'h03, '0, '0, '0, '0, 4'd1};
		rows[3]  = '{OP_WR, 12'h004, 32'haabbccdd, '0, 4'b0101, 6'h04, '0, '0, '0, '0, 4'd0};
		rows[4]  = '{OP_RD, '0, '0, '0, '0, '0, 12'h004, 6'h05, 32'h11bb33dd, '1, RND};
		rows[5]  = '{OP_WR, 12'h010, '0, '1, 4'hf, 6'h2a, '0, '0, '0, '0, RND};
		rows[6]  = '{OP_RD, '0, '0, '0, '0, '0, 12'h010, 6'h3f, '0, '0, RND};
		rows[7]  = '{OP_BOTH, 12'h020, '0, '1, 4'hf, 6'h07, 12'h000, 6'h08, 32'hdeadbeef, '1, RND};
		// Word 256 wraps onto word 0
		rows[8]  = '{OP_WR, 12'h402, 32'hcafef00d, '0, 4'hf, 6'h09, '0, '0, '0, '0, 4'd2};
		rows[9]  = '{OP_RD, '0, '0, '0, '0, '0, 12'h000, 6'h0a, 32'hcafef00d, '1, 4'd2};
		rows[10] = '{OP_BOTH, 12'h008, 32'h0f0f0f0f, '0, 4'hf, 6'h15, 12'h020, 6'h16, '0, '0, RND};
		rows[11] = '{OP_RD, '0, '0, '0, '0, '0, 12'h808, 6'h20, 32'h0f0f0f0f, '1, 4'd3};
		rows[12] = '{OP_WR, 12'h010, '0, '1, 4'b0010, 6'h11, '0, '0, '0, '0, 4'd1};
		rows[13] = '{OP_RD, '0, '0, '0, '0, '0, 12'h010, 6'h12, '0, '0, RND};
	endtask

	function automatic int pick_delay(logic [3:0] d);
		return (d == RND) ? int'($urandom % 5) : int'(d);
	endfunction

	// Called on a falling edge, returns on a falling edge
	task automatic write_transfer(input logic [11:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input id_t id, input int dly);
		AWADDR = addr_t'(addr);
		AWID = id;
		WDATA = data;
		WSTRB = strb;
		AWVALID = 1'b1;
		WVALID = 1'b1;
		@(negedge ACLK);
		while (!AWREADY)
			@(negedge ACLK);
		@(negedge ACLK);
		AWVALID = 1'b0;
		WVALID = 1'b0;
		while (!BVALID)
			@(negedge ACLK);
		repeat (dly) @(negedge ACLK);
		BREADY = 1'b1;
		@(negedge ACLK);
		BREADY = 1'b0;
	endtask

	task automatic read_transfer(input logic [11:0] addr, input id_t id, input int dly);
		ARADDR = addr_t'(addr);
		ARID = id;
		ARVALID = 1'b1;
		@(negedge ACLK);
		while (!ARREADY)
			@(negedge ACLK);
		@(negedge ACLK);
		ARVALID = 1'b0;
		while (!RVALID)
			@(negedge ACLK);
		repeat (dly) @(negedge ACLK);
		RREADY = 1'b1;
		@(negedge ACLK);
		RREADY = 1'b0;
	endtask

	task automatic apply_row(input row_t r);
		logic [31:0] data;
		int wdly;
		int rdly;
		data = r.rnd_data ? $urandom : r.wdata;
		wdly = pick_delay(r.dly);
		rdly = pick_delay(r.dly);
		tbl_rdata = r.rdata;
		tbl_chk = r.chk;
		case (r.op)
			OP_WR: write_transfer(r.waddr, data, r.strb, r.wid, wdly);
			OP_RD: read_transfer(r.raddr, r.rid, rdly);
			default: begin
				fork
					write_transfer(r.waddr, data, r.strb, r.wid, wdly);
					read_transfer(r.raddr, r.rid, rdly);
				join
			end
		endcase
	endtask

	task automatic report_counts();
		$display("Errors: %0d, write responses %0d of %0d, read responses %0d of %0d",
			errors, writes_done, exp_writes, reads_done, exp_reads);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Run control
	//////////////////////////////////////////////////////////////////////

	always @(posedge ACLK) begin
		cycles++;
		if (cycles > MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			report_counts();
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		void'($urandom(88));
		ACLK = 1'b0;
		ARESETn = 1'b0;
		{AWADDR, AWID, AWVALID, WDATA, WSTRB, WVALID, BREADY} = '0;
		{ARADDR, ARID, ARVALID, RREADY} = '0;
		tbl_rdata = '0;
		tbl_chk = 1'b0;
		load_table();
		exp_writes = 0;
		exp_reads = 0;
		for (int n = 0; n < NUM_ROWS; n++) begin
			exp_writes += (rows[n].op != OP_RD) ? 1 : 0;
			exp_reads += (rows[n].op != OP_WR) ? 1 : 0;
		end
		repeat (2) @(posedge ACLK);
		@(negedge ACLK);
		ARESETn = 1'b1;
		@(negedge ACLK);
		for (int n = 0; n < NUM_ROWS; n++)
			apply_row(rows[n]);
		repeat (2) @(negedge ACLK);
		report_counts();
		if (errors == 0 && writes_done == exp_writes && reads_done == exp_reads) begin
			$display("TEST RESULT: PASS");
		end else begin
			if (writes_done != exp_writes || reads_done != exp_reads)
				$display("Not every request received its response");
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- project.f
verilog/axi_pkg.sv
verilog/mem_pkg.sv
verilog/dp_sram.sv
verilog/axi_write_ctrl.sv
verilog/axi_read_ctrl.sv
verilog/axi_sram_top.sv
tests/axi_sram_checker.sv
tests/tb_axi_sram.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_axi_sram
FILELIST  := project.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
